/* i2c_bridge_pkg.sv */
package i2c_bridge_pkg;

	////////////////////////////////////////////////////////////
	// AXI4-Lite bus widths
	////////////////////////////////////////////////////////////
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;

	////////////////////////////////////////////////////////////
	// I2C window and command fields
	////////////////////////////////////////////////////////////
	// Upper address half-word that selects the I2C window
	localparam logic [15:0] I2C_WINDOW_TAG = 16'h1234;
	// Fixed target device on the I2C bus
	localparam int          DEV_ID_WIDTH   = 4;
	localparam logic [DEV_ID_WIDTH-1:0] I2C_DEVICE_ID = 4'hA;
	// Register address and payload byte widths
	localparam int REG_ADDR_WIDTH = 7;
	localparam int CMD_DATA_WIDTH = 8;

	// Command queue sizing
	localparam int CMD_FIFO_DEPTH = 4;
	localparam int CMD_PTR_WIDTH  = (CMD_FIFO_DEPTH > 1) ? $clog2(CMD_FIFO_DEPTH) : 1;
	localparam int CMD_CNT_WIDTH  = $clog2(CMD_FIFO_DEPTH + 1);
	// Last valid slot, pointers wrap here
	localparam logic [CMD_PTR_WIDTH-1:0] CMD_PTR_LAST = CMD_PTR_WIDTH'(CMD_FIFO_DEPTH - 1);

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////
	// AXI response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_t;

	// One I2C write command, 19 bits
	typedef struct packed {
		logic [DEV_ID_WIDTH-1:0]   dev_id;
		logic [REG_ADDR_WIDTH-1:0] reg_addr;
		logic [CMD_DATA_WIDTH-1:0] data;
	} i2c_cmd_t;

	// Write channel FSM
	typedef enum logic [1:0] {WR_IDLE, WR_COLLECT, WR_PUSH, WR_RESPOND} wr_state_t;

	// Command issuer FSM
	typedef enum logic {ISS_IDLE, ISS_WAIT_ACK} iss_state_t;

endpackage : i2c_bridge_pkg

/* axi_write_slave.sv */
`timescale 1ns/1ps

module axi_write_slave
(
	input  logic                                  ACLK,
	input  logic                                  SYN_RESET,
	// Write address channel
	input  logic                                  awvalid,
	output logic                                  awready,
	input  logic [i2c_bridge_pkg::ADDR_WIDTH-1:0] awaddr,
	// Write data channel
	input  logic                                  wvalid,
	output logic                                  wready,
	input  logic [i2c_bridge_pkg::DATA_WIDTH-1:0] wdata,
	// Write response channel
	output logic                                  bvalid,
	input  logic                                  bready,
	output i2c_bridge_pkg::axi_resp_t             bresp,
	// Command FIFO write side
	input  logic                                  full,
	output logic                                  push,
	output i2c_bridge_pkg::i2c_cmd_t              push_cmd
);
	import i2c_bridge_pkg::*;

	wr_state_t state;
	wr_state_t state_nxt;

	// Channel handshakes
	logic aw_hs;
	logic w_hs;
	logic b_hs;
	// Address and data hold flags
	logic aw_held;
	logic w_held;
	logic aw_done;
	logic w_done;
	logic accept;
	// Captured write fields
	logic                      addr_hit;
	logic [REG_ADDR_WIDTH-1:0] addr_reg;
	logic [CMD_DATA_WIDTH-1:0] data_byte;

	assign aw_hs  = awvalid & awready;
	assign w_hs   = wvalid & wready;
	assign b_hs   = bvalid & bready;
	// New beats only taken while no write is in the push or response phase
	assign accept = (state == WR_IDLE) || (state == WR_COLLECT);
	// Held now, or held after this edge
	assign aw_done = aw_held | aw_hs;
	assign w_done  = w_held | w_hs;

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////
	always_comb
	begin
		state_nxt = state;
		case (state)
			WR_IDLE, WR_COLLECT:
			begin
				// Both halves in hand, go build the command
				if (aw_done && w_done)
					state_nxt = WR_PUSH;
				else if (aw_done || w_done)
					state_nxt = WR_COLLECT;
			end
			WR_PUSH:
			begin
				// A miss skips the FIFO; a hit waits for room
				if (!addr_hit || !full)
					state_nxt = WR_RESPOND;
			end
			WR_RESPOND:
			begin
				if (b_hs)
					state_nxt = WR_IDLE;
			end
			default:
			begin
				state_nxt = WR_IDLE;
			end
		endcase
	end

	always_ff @(posedge ACLK or negedge SYN_RESET)
	begin
		if (!SYN_RESET)
			state <= WR_IDLE;
		else
			state <= state_nxt;
	end

	////////////////////////////////////////////////////////////
	// AW and W acceptance
	////////////////////////////////////////////////////////////
	always_ff @(posedge ACLK or negedge SYN_RESET)
	begin
		if (!SYN_RESET)
		begin
			awready <= 1'b0;
			wready  <= 1'b0;
			aw_held <= 1'b0;
			w_held  <= 1'b0;
		end
		else
		begin
			// One-cycle ready pulse, one cycle after valid is seen
			awready <= accept && awvalid && !aw_held && !awready;
			wready  <= accept && wvalid && !w_held && !wready;
			// Flags clear once the response is taken
			if (b_hs)
			begin
				aw_held <= 1'b0;
				w_held  <= 1'b0;
			end
			else
			begin
				if (aw_hs)
					aw_held <= 1'b1;
				if (w_hs)
					w_held <= 1'b1;
			end
		end
	end

	// Window check and field capture at each handshake
	always_ff @(posedge ACLK)
	begin
		if (aw_hs)
		begin
			addr_hit <= (awaddr[ADDR_WIDTH-1 -: $bits(I2C_WINDOW_TAG)] == I2C_WINDOW_TAG);
			addr_reg <= awaddr[REG_ADDR_WIDTH-1:0];
		end
		if (w_hs)
			data_byte <= wdata[CMD_DATA_WIDTH-1:0];
	end

	////////////////////////////////////////////////////////////
	// Command push and B channel
	////////////////////////////////////////////////////////////
	assign push_cmd = '{dev_id: I2C_DEVICE_ID, reg_addr: addr_reg, data: data_byte};
	// Strobe only on the cycle the FIFO has room
	assign push     = (state == WR_PUSH) && addr_hit && !full;

	always_ff @(posedge ACLK or negedge SYN_RESET)
	begin
		if (!SYN_RESET)
		begin
			bvalid <= 1'b0;
			bresp  <= OKAY;
		end
		else if ((state == WR_PUSH) && (state_nxt == WR_RESPOND))
		begin
			// Posted response, cmd is already queued or dropped
			bvalid <= 1'b1;
			bresp  <= addr_hit ? OKAY : SLVERR;
		end
		else if (b_hs)
			bvalid <= 1'b0;
	end

endmodule : axi_write_slave

/* cmd_fifo.sv */
`timescale 1ns/1ps

module cmd_fifo
(
	input  logic                     ACLK,
	input  logic                     SYN_RESET,
	// Write side
	input  logic                     push,
	input  i2c_bridge_pkg::i2c_cmd_t push_cmd,
	// Read side
	input  logic                     pop,
	output i2c_bridge_pkg::i2c_cmd_t head_cmd,
	// Status
	output logic                     empty,
	output logic                     full
);
	import i2c_bridge_pkg::*;

	// Command storage
	i2c_cmd_t                 mem [CMD_FIFO_DEPTH];
	logic [CMD_PTR_WIDTH-1:0] wr_ptr;
	logic [CMD_PTR_WIDTH-1:0] rd_ptr;
	logic [CMD_CNT_WIDTH-1:0] count;

	// Circular pointer advance
	function automatic logic [CMD_PTR_WIDTH-1:0] ptr_inc(input logic [CMD_PTR_WIDTH-1:0] ptr);
		if (ptr == CMD_PTR_LAST)
			return '0;
		else
			return ptr + 1'b1;
	endfunction

	////////////////////////////////////////////////////////////
	// Storage write
	////////////////////////////////////////////////////////////
	always_ff @(posedge ACLK)
	begin
		if (push)
			mem[wr_ptr] <= push_cmd;
	end

	// First-word fall-through head
	assign head_cmd = mem[rd_ptr];

	////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////
	always_ff @(posedge ACLK or negedge SYN_RESET)
	begin
		if (!SYN_RESET)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			// Simultaneous push and pop leaves count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Status straight from the registered count
	assign empty = (count == '0);
	assign full  = (count == CMD_CNT_WIDTH'(CMD_FIFO_DEPTH));

endmodule : cmd_fifo

/* i2c_cmd_issuer.sv */
`timescale 1ns/1ps

module i2c_cmd_issuer
(
	input  logic                     ACLK,
	input  logic                     SYN_RESET,
	// FIFO read side
	input  i2c_bridge_pkg::i2c_cmd_t head_cmd,
	input  logic                     empty,
	output logic                     pop,
	// I2C master side
	output i2c_bridge_pkg::i2c_cmd_t i2c_cmd,
	output logic                     i2c_req,
	input  logic                     i2c_ack
);
	import i2c_bridge_pkg::*;

	iss_state_t state;

	// Ack synchronizer stages
	logic ack_meta;
	logic ack_sync;
	// Last synchronized level, for edge detect
	logic ack_last;
	logic ack_edge;

	////////////////////////////////////////////////////////////
	// Acknowledge synchronizer
	////////////////////////////////////////////////////////////
	// i2c_ack comes from the I2C clock domain
	always_ff @(posedge ACLK or negedge SYN_RESET)
	begin
		if (!SYN_RESET)
		begin
			ack_meta <= 1'b0;
			ack_sync <= 1'b0;
			ack_last <= 1'b0;
		end
		else
		begin
			ack_meta <= i2c_ack;
			ack_sync <= ack_meta;
			ack_last <= ack_sync;
		end
	end

	// Any toggle of the ack level completes a request
	assign ack_edge = ack_sync ^ ack_last;

	////////////////////////////////////////////////////////////
	// Issue FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge ACLK or negedge SYN_RESET)
	begin
		if (!SYN_RESET)
		begin
			state   <= ISS_IDLE;
			pop     <= 1'b0;
			i2c_req <= 1'b0;
			i2c_cmd <= '0;
		end
		else
		begin
			// Pop is a single-cycle strobe
			pop <= 1'b0;
			case (state)
				ISS_IDLE:
				begin
					if (!empty)
					begin
						// Latch head and announce it with a toggle
						i2c_cmd <= head_cmd;
						i2c_req <= ~i2c_req;
						pop     <= 1'b1;
						state   <= ISS_WAIT_ACK;
					end
				end
				ISS_WAIT_ACK:
				begin
					// No timeout here, master may stretch
					if (ack_edge)
						state <= ISS_IDLE;
				end
				default:
				begin
					state <= ISS_IDLE;
				end
			endcase
		end
	end

endmodule : i2c_cmd_issuer

/* i2c_bridge_top.sv */
`timescale 1ns/1ps

module i2c_bridge_top
(
	input  logic                                  ACLK,
	input  logic                                  SYN_RESET,
	// AXI4-Lite write address
	input  logic                                  awvalid,
	output logic                                  awready,
	input  logic [i2c_bridge_pkg::ADDR_WIDTH-1:0] awaddr,
	// AXI4-Lite write data
	input  logic                                  wvalid,
	output logic                                  wready,
	input  logic [i2c_bridge_pkg::DATA_WIDTH-1:0] wdata,
	// AXI4-Lite write response
	output logic                                  bvalid,
	input  logic                                  bready,
	output i2c_bridge_pkg::axi_resp_t             bresp,
	// I2C master command interface
	output i2c_bridge_pkg::i2c_cmd_t              i2c_cmd,
	output logic                                  i2c_req,
	input  logic                                  i2c_ack
);
	import i2c_bridge_pkg::*;

	// Producer to FIFO
	logic     push;
	i2c_cmd_t push_cmd;
	logic     full;
	// FIFO to issuer
	logic     pop;
	i2c_cmd_t head_cmd;
	logic     empty;

	////////////////////////////////////////////////////////////
	// AXI write side
	////////////////////////////////////////////////////////////
	axi_write_slave i_axi_write_slave (
		.ACLK      (ACLK),
		.SYN_RESET (SYN_RESET),
		.awvalid   (awvalid),
		.awready   (awready),
		.awaddr    (awaddr),
		.wvalid    (wvalid),
		.wready    (wready),
		.wdata     (wdata),
		.bvalid    (bvalid),
		.bready    (bready),
		.bresp     (bresp),
		.full      (full),
		.push      (push),
		.push_cmd  (push_cmd)
	);

	// Command queue between the two sides
	cmd_fifo i_cmd_fifo (
		.ACLK      (ACLK),
		.SYN_RESET (SYN_RESET),
		.push      (push),
		.push_cmd  (push_cmd),
		.pop       (pop),
		.head_cmd  (head_cmd),
		.empty     (empty),
		.full      (full)
	);

	////////////////////////////////////////////////////////////
	// I2C issue side
	////////////////////////////////////////////////////////////
	i2c_cmd_issuer i_i2c_cmd_issuer (
		.ACLK      (ACLK),
		.SYN_RESET (SYN_RESET),
		.head_cmd  (head_cmd),
		.empty     (empty),
		.pop       (pop),
		.i2c_cmd   (i2c_cmd),
		.i2c_req   (i2c_req),
		.i2c_ack   (i2c_ack)
	);

endmodule : i2c_bridge_top

/* i2c_bridge_chk.sv */
`timescale 1ns/1ps

module i2c_bridge_chk
(
	input logic                      ACLK,
	input logic                      SYN_RESET,
	input logic                      bvalid,
	input logic                      bready,
	input i2c_bridge_pkg::axi_resp_t bresp,
	input logic                      i2c_req,
	input i2c_bridge_pkg::i2c_cmd_t  i2c_cmd,
	input logic                      push,
	input logic                      full
);

	////////////////////////////////////////////////////////////
	// B channel
	////////////////////////////////////////////////////////////
	// Response held until the master takes it
	assert_b_hold: assert property (@(posedge ACLK) disable iff (!SYN_RESET)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("bvalid or bresp changed before bready");

	////////////////////////////////////////////////////////////
	// I2C command side
	////////////////////////////////////////////////////////////
	// Command only moves together with a request toggle
	assert_cmd_stable: assert property (@(posedge ACLK) disable iff (!SYN_RESET)
		$stable(i2c_req) |-> $stable(i2c_cmd))
		else $error("i2c_cmd changed without a request toggle");

	// No write into a full queue
	assert_no_push_full: assert property (@(posedge ACLK) disable iff (!SYN_RESET)
		!(push && full))
		else $error("push while the command FIFO is full");

endmodule : i2c_bridge_chk

// Internal FIFO strobes picked up from the top level scope
bind i2c_bridge_top i2c_bridge_chk i_chk (
	.ACLK      (ACLK),
	.SYN_RESET (SYN_RESET),
	.bvalid    (bvalid),
	.bready    (bready),
	.bresp     (bresp),
	.i2c_req   (i2c_req),
	.i2c_cmd   (i2c_cmd),
	.push      (push),
	.full      (full)
);

/* tb_i2c_bridge.sv */
`timescale 1ns/1ps

module tb_i2c_bridge;
	import i2c_bridge_pkg::*;

	// Cycle limits for each wait loop
	localparam int HANDSHAKE_TIMEOUT = 1000;
	localparam int DRAIN_TIMEOUT     = 2000;

	logic                  ACLK;
	logic                  SYN_RESET;
	logic                  awvalid;
	logic                  awready;
	logic [ADDR_WIDTH-1:0] awaddr;
	logic                  wvalid;
	logic                  wready;
	logic [DATA_WIDTH-1:0] wdata;
	logic                  bvalid;
	logic                  bready;
	axi_resp_t             bresp;
	i2c_cmd_t              i2c_cmd;
	logic                  i2c_req;
	logic                  i2c_ack;

	// Golden writes, one entry each
	logic [ADDR_WIDTH-1:0] vec_addr [$];
	logic [DATA_WIDTH-1:0] vec_data [$];
	int                    vec_order [$];
	axi_resp_t             vec_resp [$];
	// Commands still owed by the DUT, oldest first
	i2c_cmd_t              exp_cmds [$];

	i2c_bridge_top i_dut (
		.ACLK      (ACLK),
		.SYN_RESET (SYN_RESET),
		.awvalid   (awvalid),
		.awready   (awready),
		.awaddr    (awaddr),
		.wvalid    (wvalid),
		.wready    (wready),
		.wdata     (wdata),
		.bvalid    (bvalid),
		.bready    (bready),
		.bresp     (bresp),
		.i2c_cmd   (i2c_cmd),
		.i2c_req   (i2c_req),
		.i2c_ack   (i2c_ack)
	);

	// 20 ns period
	always #10 ACLK = ~ACLK;

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic compare_resp(input axi_resp_t got, input axi_resp_t exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED bresp got 0x%0h expected 0x%0h", got, exp));
	endtask

	task automatic compare_cmd(input i2c_cmd_t got, input i2c_cmd_t exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED i2c_cmd got 0x%05h expected 0x%05h", got, exp));
	endtask

	// Columns: addr, data, order, resp, command in hex or none
	task automatic load_golden();
		int                    fd;
		int                    code;
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] data;
		int                    order;
		logic [1:0]            resp;
		logic [63:0]           tok;
		logic [31:0]           cmd_raw;
		fd = $fopen("i2c_bridge_golden.txt", "r");
		if (fd == 0)
			abort_run("could not open i2c_bridge_golden.txt");
		while (!$feof(fd))
		begin
			code = $fscanf(fd, "%h %h %d %h %s\n", addr, data, order, resp, tok);
			if (code == 5)
			begin
				vec_addr.push_back(addr);
				vec_data.push_back(data);
				vec_order.push_back(order);
				vec_resp.push_back(axi_resp_t'(resp));
				// Misses owe no command
				if (tok != 64'("none"))
				begin
					code = $sscanf(tok, "%h", cmd_raw);
					exp_cmds.push_back(i2c_cmd_t'(cmd_raw[$bits(i2c_cmd_t)-1:0]));
				end
			end
			else if (!$feof(fd))
				abort_run("malformed line in i2c_bridge_golden.txt");
		end
		$fclose(fd);
		if (vec_addr.size() == 0)
			abort_run("golden file holds no writes");
	endtask

	////////////////////////////////////////////////////////////
	// AXI master driver
	////////////////////////////////////////////////////////////
	// Order 0 address first, 1 data first, 2 both together
	task automatic do_write(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data,
		input int order, input axi_resp_t exp_resp);
		bit aw_seen;
		bit w_seen;
		int cycles;
		aw_seen = 1'b0;
		w_seen  = 1'b0;
		cycles  = 0;
		@(posedge ACLK);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= (order != 1);
		wvalid  <= (order != 0);
		while (!(aw_seen && w_seen))
		begin
			@(posedge ACLK);
			cycles++;
			if (cycles > HANDSHAKE_TIMEOUT)
				abort_run($sformatf("timed out waiting for %s", awvalid ? "awready" : "wready"));
			// Second channel starts once the first one is taken
			if (awvalid && awready)
			begin
				aw_seen = 1'b1;
				awvalid <= 1'b0;
				if (!w_seen)
					wvalid <= 1'b1;
			end
			if (wvalid && wready)
			begin
				w_seen = 1'b1;
				wvalid <= 1'b0;
				if (!aw_seen)
					awvalid <= 1'b1;
			end
		end
		cycles = 0;
		do
		begin
			@(posedge ACLK);
			cycles++;
			if (cycles > HANDSHAKE_TIMEOUT)
				abort_run("timed out waiting for bvalid");
		end while (!bvalid);
		compare_resp(bresp, exp_resp);
		// bready one cycle late, so bvalid has to hold
		bready <= 1'b1;
		@(posedge ACLK);
		bready <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// I2C responder
	////////////////////////////////////////////////////////////
	initial
	begin : responder
		logic req_last;
		int   delay;
		void'($urandom(32'h9db5));
		req_last = 1'b0;
		forever
		begin
			@(posedge ACLK);
			// Only watch the request once the DUT is out of reset
			if (SYN_RESET && (i2c_req !== req_last))
			begin
				req_last = i2c_req;
				if (exp_cmds.size() == 0)
					abort_run("request toggle seen with no command expected");
				compare_cmd(i2c_cmd, exp_cmds.pop_front());
				// Slow ack lets the FIFO fill up
				delay = $urandom_range(40, 1);
				repeat (delay) @(posedge ACLK);
				i2c_ack <= ~i2c_ack;
			end
		end
	end

	initial
	begin
		int cycles;
		ACLK      = 1'b0;
		SYN_RESET = 1'b0;
		awvalid   = 1'b0;
		awaddr    = '0;
		wvalid    = 1'b0;
		wdata     = '0;
		bready    = 1'b0;
		i2c_ack   = 1'b0;
		load_golden();
		repeat (10) @(posedge ACLK);
		SYN_RESET <= 1'b1;
		// Idle outputs out of reset
		@(posedge ACLK);
		compare_flag("awready", awready, 1'b0);
		compare_flag("wready", wready, 1'b0);
		compare_flag("bvalid", bvalid, 1'b0);
		compare_flag("i2c_req", i2c_req, 1'b0);
		for (int i = 0; i < vec_addr.size(); i++)
			do_write(vec_addr[i], vec_data[i], vec_order[i], vec_resp[i]);
		// Drain what the I2C side still owes
		cycles = 0;
		while ((exp_cmds.size() != 0) && (cycles < DRAIN_TIMEOUT))
		begin
			@(posedge ACLK);
			cycles++;
		end
		// Window for a stray extra toggle
		repeat (60) @(posedge ACLK);
		if (exp_cmds.size() == 0)
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
			abort_run("timed out waiting for a request toggle, commands never issued");
	end

endmodule : tb_i2c_bridge

/* i2c_bridge_golden.txt */
12340010 000000A5 0 0 510A5
1234007F FFFFFF3C 1 0 57F3C
56780010 00000011 2 2 none
12340081 12345678 2 0 50178
00000005 00000022 0 2 none
12340002 00000000 1 0 50200
12340003 00000001 0 0 50301
12340004 00000002 1 0 50402
12340005 00000003 2 0 50503
12340006 00000004 0 0 50604
1235000A 000000EE 1 2 none
12340007 00000005 2 0 50705
1234004B 000000C3 0 0 54BC3
1234FFFF 0000000F 1 0 57F0F

/* i2c_bridge.f */
i2c_bridge_pkg.sv
axi_write_slave.sv
cmd_fifo.sv
i2c_cmd_issuer.sv
i2c_bridge_top.sv
i2c_bridge_chk.sv
tb_i2c_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the AXI to I2C bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_i2c_bridge -f i2c_bridge.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "CHECKS FAILED" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

if ! grep -qx "ALL CHECKS PASSED" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi

exit 0
